// File: design/eeprom_defs.svh
`ifndef EEPROM_DEFS_SVH
`define EEPROM_DEFS_SVH

// clk cycles per quarter scl period
`define EE_SCL_QTR 4

// 24cxx device type code, upper nibble of the control byte
`define EE_DEV_TYPE 4'b1010

// wishbone word offsets
`define EE_REG_ADDR  2'd0
`define EE_REG_WDATA 2'd1
`define EE_REG_CMD   2'd2   // status on read

// command register codes
`define EE_CMD_WRITE 2'd1
`define EE_CMD_READ  2'd2

`endif

// File: design/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    // bit engine commands
    typedef enum logic [2:0] {
        BIT_NONE  = 3'd0,
        BIT_START = 3'd1,
        BIT_STOP  = 3'd2,
        BIT_WRITE = 3'd3,
        BIT_READ  = 3'd4
    } bit_cmd_t;

    // one-hot transfer sequencer states
    typedef enum logic [10:0] {
        SEQ_IDLE    = 11'b000_0000_0001,
        SEQ_START   = 11'b000_0000_0010,
        SEQ_CTRL_WR = 11'b000_0000_0100,
        SEQ_ADDR_WR = 11'b000_0000_1000,
        SEQ_DATA_WR = 11'b000_0001_0000,
        SEQ_RESTART = 11'b000_0010_0000,
        SEQ_CTRL_RD = 11'b000_0100_0000,
        SEQ_DATA_RD = 11'b000_1000_0000,
        SEQ_NACK    = 11'b001_0000_0000,
        SEQ_STOP    = 11'b010_0000_0000,
        SEQ_FINISH  = 11'b100_0000_0000
    } seq_state_t;

endpackage

`default_nettype wire

// File: design/eeprom_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_defs.svh"

module eeprom_wb_regs (
    input  wire logic        CLK,
    input  wire logic        RESET,
    input  wire logic        wb_cyc,
    input  wire logic        wb_stb,
    input  wire logic        wb_we,
    input  wire logic [1:0]  wb_adr,
    input  wire logic [15:0] wb_dat_i,
    output logic      [15:0] wb_dat_o,
    output logic             wb_ack,
    output logic             start_wr,
    output logic             start_rd,
    output logic      [10:0] mem_addr,
    output logic      [7:0]  wdata,
    input  wire logic        busy,
    input  wire logic        nack,
    input  wire logic [7:0]  rdata
);

    logic req;
    logic cmd_wr;
    logic cmd_ok;

    assign req    = wb_cyc && wb_stb && !wb_ack;   // one access per ack
    assign cmd_wr = req && wb_we && (wb_adr == `EE_REG_CMD);
    // pulse still in flight counts as busy
    assign cmd_ok = !busy && !start_wr && !start_rd;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wb_ack   <= 1'b0;
            start_wr <= 1'b0;
            start_rd <= 1'b0;
        end
        else
        begin
            wb_ack   <= req;
            start_wr <= cmd_wr && cmd_ok && (wb_dat_i[1:0] == `EE_CMD_WRITE);
            start_rd <= cmd_wr && cmd_ok && (wb_dat_i[1:0] == `EE_CMD_READ);
        end
    end

    always_ff @(posedge CLK)
    begin
        if (req && wb_we)
        begin
            case (wb_adr)
                `EE_REG_ADDR:  mem_addr <= wb_dat_i[10:0];
                `EE_REG_WDATA: wdata    <= wb_dat_i[7:0];
                default: ;
            endcase
        end
        if (req && !wb_we)
        begin
            case (wb_adr)
                `EE_REG_ADDR:  wb_dat_o <= {5'd0, mem_addr};
                `EE_REG_WDATA: wb_dat_o <= {8'd0, wdata};
                `EE_REG_CMD:   wb_dat_o <= {rdata, 6'd0, nack, busy};
                default:       wb_dat_o <= 16'd0;
            endcase
        end
    end

    // start pulse only reaches an idle sequencer
    a_start_idle: assert property (@(posedge CLK) disable iff (RESET)
        (start_wr || start_rd) |-> !busy);

endmodule

`default_nettype wire

// File: design/eeprom_byte_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_defs.svh"

module eeprom_byte_fsm import eeprom_pkg::*; (
    input  wire logic        CLK,
    input  wire logic        RESET,
    input  wire logic        start_wr,
    input  wire logic        start_rd,
    input  wire logic [10:0] mem_addr,
    input  wire logic [7:0]  wdata,
    output logic             busy,
    output logic             nack,
    output logic      [7:0]  rdata,
    output bit_cmd_t         cmd,
    output logic             bit_out,
    input  wire logic        ready,
    input  wire logic        bit_done,
    input  wire logic        bit_in
);

    seq_state_t  state;
    logic        pend;      // command out, waiting for bit_done
    logic [3:0]  bcnt;      // 0..7 data, 8 ack
    logic [7:0]  sbuf;
    logic [10:0] addr_q;
    logic [7:0]  wd_q;
    logic        rd_op;

    always_comb
    begin
        cmd     = BIT_NONE;
        bit_out = 1'b1;
        if (!pend)
        begin
            case (state)
                SEQ_START, SEQ_RESTART: cmd = BIT_START;
                SEQ_CTRL_WR, SEQ_ADDR_WR, SEQ_DATA_WR, SEQ_CTRL_RD:
                begin
                    cmd     = (bcnt == 4'd8) ? BIT_READ : BIT_WRITE;
                    bit_out = sbuf[7];   // msb first
                end
                SEQ_DATA_RD: cmd = BIT_READ;
                SEQ_NACK:    cmd = BIT_WRITE;   // bit_out stays high
                SEQ_STOP:    cmd = BIT_STOP;
                default:     cmd = BIT_NONE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= SEQ_IDLE;
            pend  <= 1'b0;
            busy  <= 1'b0;
            nack  <= 1'b0;
            bcnt  <= 4'd0;
        end
        else
        begin
            if (cmd != BIT_NONE)
                pend <= 1'b1;
            else if (bit_done)
                pend <= 1'b0;

            case (state)
                SEQ_IDLE:
                begin
                    if (start_wr || start_rd)
                    begin
                        addr_q <= mem_addr;
                        wd_q   <= wdata;
                        rd_op  <= start_rd;
                        busy   <= 1'b1;
                        nack   <= 1'b0;
                        state  <= SEQ_START;
                    end
                end
                SEQ_START, SEQ_RESTART:
                begin
                    if (bit_done)
                    begin
                        bcnt  <= 4'd0;
                        sbuf  <= {`EE_DEV_TYPE, addr_q[10:8], (state == SEQ_RESTART)};
                        state <= (state == SEQ_RESTART) ? SEQ_CTRL_RD : SEQ_CTRL_WR;
                    end
                end
                SEQ_CTRL_WR, SEQ_ADDR_WR, SEQ_DATA_WR, SEQ_CTRL_RD:
                begin
                    if (bit_done)
                    begin
                        if (bcnt != 4'd8)
                        begin
                            sbuf <= {sbuf[6:0], 1'b0};
                            bcnt <= bcnt + 4'd1;
                        end
                        else if (bit_in)   // no ack from slave
                        begin
                            nack  <= 1'b1;
                            state <= SEQ_STOP;
                        end
                        else
                        begin
                            bcnt <= 4'd0;
                            case (state)
                                SEQ_CTRL_WR:
                                begin
                                    sbuf  <= addr_q[7:0];
                                    state <= SEQ_ADDR_WR;
                                end
                                SEQ_ADDR_WR:
                                begin
                                    sbuf  <= wd_q;
                                    state <= rd_op ? SEQ_RESTART : SEQ_DATA_WR;
                                end
                                SEQ_CTRL_RD: state <= SEQ_DATA_RD;
                                default:     state <= SEQ_STOP;
                            endcase
                        end
                    end
                end
                SEQ_DATA_RD:
                begin
                    if (bit_done)
                    begin
                        sbuf <= {sbuf[6:0], bit_in};
                        bcnt <= bcnt + 4'd1;
                        if (bcnt == 4'd7)
                        begin
                            rdata <= {sbuf[6:0], bit_in};
                            state <= SEQ_NACK;
                        end
                    end
                end
                SEQ_NACK:
                begin
                    if (bit_done)
                        state <= SEQ_STOP;
                end
                SEQ_STOP:
                begin
                    if (bit_done)
                        state <= SEQ_FINISH;
                end
                SEQ_FINISH:
                begin
                    busy  <= 1'b0;
                    state <= SEQ_IDLE;
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // bit engine handshake
    a_cmd_ready: assert property (@(posedge CLK) disable iff (RESET)
        !ready |-> (cmd == BIT_NONE));

endmodule

`default_nettype wire

// File: design/i2c_bit_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_defs.svh"

module i2c_bit_ctrl import eeprom_pkg::*; (
    input  wire logic     CLK,
    input  wire logic     RESET,
    input  wire bit_cmd_t cmd,
    input  wire logic     bit_out,
    output logic          ready,
    output logic          bit_done,
    output logic          bit_in,
    output logic          scl,
    output logic          sda_oe,
    input  wire logic     sda_in
);

    localparam int QTR = `EE_SCL_QTR;

    logic [7:0] qcnt;
    logic [1:0] phase;
    bit_cmd_t   op;
    logic       bout;

    // {scl, sda_oe} for each quarter of a command
    function automatic logic [1:0] line_state(input bit_cmd_t c, input logic b,
                                              input logic [1:0] p);
        logic [1:0] ls;
        case (c)
            BIT_START:
            begin
                case (p)
                    2'd0:    ls = 2'b00;
                    2'd1:    ls = 2'b10;
                    2'd2:    ls = 2'b11;   // sda falls, scl high
                    default: ls = 2'b01;
                endcase
            end
            BIT_STOP:
            begin
                case (p)
                    2'd0:    ls = 2'b01;
                    2'd1:    ls = 2'b11;
                    default: ls = 2'b10;   // sda rises, scl high
                endcase
            end
            default:
            begin
                ls[1] = (p == 2'd1) || (p == 2'd2);
                ls[0] = (c == BIT_WRITE) && !b;
            end
        endcase
        return ls;
    endfunction

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            ready    <= 1'b1;
            bit_done <= 1'b0;
            scl      <= 1'b1;
            sda_oe   <= 1'b0;
            op       <= BIT_NONE;
            phase    <= 2'd0;
            qcnt     <= 8'd0;
        end
        else
        begin
            bit_done <= 1'b0;
            if (ready)
            begin
                if (cmd != BIT_NONE)
                begin
                    ready         <= 1'b0;
                    op            <= cmd;
                    bout          <= bit_out;
                    phase         <= 2'd0;
                    qcnt          <= 8'd0;
                    {scl, sda_oe} <= line_state(cmd, bit_out, 2'd0);
                end
            end
            else if (qcnt == 8'(QTR - 1))
            begin
                qcnt <= 8'd0;
                if (phase == 2'd3)
                begin
                    ready    <= 1'b1;
                    bit_done <= 1'b1;
                end
                else
                begin
                    phase         <= phase + 2'd1;
                    {scl, sda_oe} <= line_state(op, bout, phase + 2'd1);
                    if (phase == 2'd1)
                        bit_in <= sda_in;   // middle of scl high
                end
            end
            else
            begin
                qcnt <= qcnt + 8'd1;
            end
        end
    end

    // sda only moves under high scl for start and stop
    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && $changed(sda_oe)) |-> (op inside {BIT_START, BIT_STOP}));

endmodule

`default_nettype wire

// File: design/eeprom_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_top import eeprom_pkg::*; (
    input  wire logic        CLK,
    input  wire logic        RESET,
    input  wire logic        wb_cyc,
    input  wire logic        wb_stb,
    input  wire logic        wb_we,
    input  wire logic [1:0]  wb_adr,
    input  wire logic [15:0] wb_dat_i,
    output logic      [15:0] wb_dat_o,
    output logic             wb_ack,
    output logic             scl,
    output logic             sda_oe,   // high pulls sda low
    input  wire logic        sda_in
);

    logic        start_wr;
    logic        start_rd;
    logic [10:0] mem_addr;
    logic [7:0]  wdata;
    logic        busy;
    logic        nack;
    logic [7:0]  rdata;
    bit_cmd_t    cmd;
    logic        bit_out;
    logic        ready;
    logic        bit_done;
    logic        bit_in;

    eeprom_wb_regs u_regs (
        .CLK      (CLK),
        .RESET    (RESET),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .start_wr (start_wr),
        .start_rd (start_rd),
        .mem_addr (mem_addr),
        .wdata    (wdata),
        .busy     (busy),
        .nack     (nack),
        .rdata    (rdata)
    );

    eeprom_byte_fsm u_seq (
        .CLK      (CLK),
        .RESET    (RESET),
        .start_wr (start_wr),
        .start_rd (start_rd),
        .mem_addr (mem_addr),
        .wdata    (wdata),
        .busy     (busy),
        .nack     (nack),
        .rdata    (rdata),
        .cmd      (cmd),
        .bit_out  (bit_out),
        .ready    (ready),
        .bit_done (bit_done),
        .bit_in   (bit_in)
    );

    i2c_bit_ctrl u_bit (
        .CLK      (CLK),
        .RESET    (RESET),
        .cmd      (cmd),
        .bit_out  (bit_out),
        .ready    (ready),
        .bit_done (bit_done),
        .bit_in   (bit_in),
        .scl      (scl),
        .sda_oe   (sda_oe),
        .sda_in   (sda_in)
    );

endmodule

`default_nettype wire

// File: verification/i2c_eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_defs.svh"

module i2c_eeprom_model (
    input  wire logic CLK,
    input  wire logic RESET,
    input  wire logic scl,
    input  wire logic sda,
    input  wire logic absent,       // never acknowledge
    output logic      sda_pull,     // high pulls sda low
    output int        stops,
    output int        proto_errs
);

    localparam logic [1:0] M_CTRL = 2'd0;
    localparam logic [1:0] M_WADDR = 2'd1;
    localparam logic [1:0] M_WDATA = 2'd2;
    localparam logic [1:0] M_TX = 2'd3;

    logic [7:0] mem [0:2047];
    logic       prev_scl;
    logic       prev_sda;
    logic       active;
    logic       skip;       // rest of the transfer is ignored
    logic [3:0] bcnt;
    logic [1:0] mode;
    logic [7:0] sr;
    logic [7:0] tx;
    logic [7:0] waddr;
    logic [2:0] page;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ {3'(i >> 8), 2'b00, 3'(i >> 8)};
    end

    always @(posedge CLK)
    begin : bus
        logic ack_now;
        ack_now = !absent;
        if (RESET)
        begin
            prev_scl   <= 1'b1;
            prev_sda   <= 1'b1;
            active     <= 1'b0;
            sda_pull   <= 1'b0;
            bcnt       <= 4'd0;
            stops      <= 0;
            proto_errs <= 0;
        end
        else
        begin
            prev_scl <= scl;
            prev_sda <= sda;
            if (scl && prev_scl && (sda !== prev_sda))
            begin
                if (active && bcnt != 4'd0)
                begin
                    $display("protocol error: sda changed while scl high inside a byte at %0t",
                             $time);
                    proto_errs <= proto_errs + 1;
                    active     <= 1'b0;
                    sda_pull   <= 1'b0;
                end
                else if (!sda)  // start or repeated start
                begin
                    active   <= 1'b1;
                    skip     <= 1'b0;
                    bcnt     <= 4'd8;   // next scl fall closes the start
                    mode     <= M_CTRL;
                    sda_pull <= 1'b0;
                end
                else
                begin
                    stops    <= stops + 1;
                    active   <= 1'b0;
                    sda_pull <= 1'b0;
                end
            end
            else if (active && scl && !prev_scl)
            begin
                if (bcnt < 4'd8)
                    sr <= {sr[6:0], sda};
                else if (mode == M_TX && sda)
                    skip <= 1'b1;       // master nack ends the read
            end
            else if (active && !scl && prev_scl)
            begin
                if (bcnt < 4'd7)
                begin
                    bcnt <= bcnt + 4'd1;
                    if (mode == M_TX && !skip)
                        sda_pull <= !tx[3'd6 - bcnt[2:0]];
                end
                else if (bcnt == 4'd7)
                begin
                    bcnt     <= 4'd8;
                    sda_pull <= 1'b0;
                    if (mode != M_TX && !skip)
                    begin
                        case (mode)
                            M_CTRL:
                            begin
                                if (sr[7:4] != `EE_DEV_TYPE)
                                    ack_now = 1'b0;
                                else if (sr[0])
                                begin
                                    mode <= M_TX;
                                    tx   <= mem[{sr[3:1], waddr}];
                                end
                                else
                                begin
                                    page <= sr[3:1];
                                    mode <= M_WADDR;
                                end
                            end
                            M_WADDR:
                            begin
                                waddr <= sr;
                                mode  <= M_WDATA;
                            end
                            default:
                            begin
                                mem[{page, waddr}] <= sr;  // no write cycle delay
                                skip <= 1'b1;
                            end
                        endcase
                        if (!ack_now)
                            skip <= 1'b1;
                        sda_pull <= ack_now;
                    end
                end
                else
                begin
                    bcnt     <= 4'd0;
                    sda_pull <= (mode == M_TX && !skip) ? !tx[7] : 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_eeprom_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_defs.svh"

module tb_eeprom_ctrl;

    localparam int NUM_TESTS = 12;
    localparam int LIMIT = NUM_TESTS * 39 * 4 * `EE_SCL_QTR * 2;
    localparam int OP_WR = 0;
    localparam int OP_RD = 1;
    localparam int OP_WR_BUSY = 2;   // second command sent while busy

    logic        CLK = 1'b0;
    logic        RESET = 1'b1;
    logic        wb_cyc = 1'b0;
    logic        wb_stb = 1'b0;
    logic        wb_we = 1'b0;
    logic [1:0]  wb_adr = 2'd0;
    logic [15:0] wb_dat_i = 16'd0;
    logic [15:0] wb_dat_o;
    logic        wb_ack;
    logic        scl;
    logic        sda_oe;
    logic        sda_pull;
    logic        model_absent = 1'b0;
    logic        sda_line;
    int          stops;
    int          proto_errs;

    string       t_name [NUM_TESTS];
    int          t_op [NUM_TESTS];
    logic [10:0] t_addr [NUM_TESTS];
    logic        t_absent [NUM_TESTS];
    logic        t_nack [NUM_TESTS];

    logic [7:0]  ref_mem [0:2047];
    logic [15:0] lfsr = 16'd87;
    int          errors = 0;
    int          cycles = 0;
    string       cur_name = "reset";

    assign sda_line = !(sda_oe || sda_pull);   // wired-and with pull-up

    eeprom_ctrl_top u_dut (
        .CLK      (CLK),
        .RESET    (RESET),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .scl      (scl),
        .sda_oe   (sda_oe),
        .sda_in   (sda_line)
    );

    i2c_eeprom_model u_mem (
        .CLK        (CLK),
        .RESET      (RESET),
        .scl        (scl),
        .sda        (sda_line),
        .absent     (model_absent),
        .sda_pull   (sda_pull),
        .stops      (stops),
        .proto_errs (proto_errs)
    );

    always #20 CLK = !CLK;

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT)
        begin
            $display("timeout: run passed %0d cycles in test %s", LIMIT, cur_name);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++)
        begin
            b    = {b[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check(input string name, input int exp, input int act);
        if (exp != act)
        begin
            $display("FAIL %s expected 0x%0h actual 0x%0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic set_test(input int i, input string name, input int op,
                            input logic [10:0] addr, input logic absent, input logic nack);
        t_name[i]   = name;
        t_op[i]     = op;
        t_addr[i]   = addr;
        t_absent[i] = absent;
        t_nack[i]   = nack;
    endtask

    // ack must come exactly one cycle after the strobe
    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [15:0] dat,
                             output logic [15:0] rd);
        int n;
        n = 0;
        @(posedge CLK);
        #2;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = dat;
        do
        begin
            @(posedge CLK);
            n++;
            #1;
        end
        while (!wb_ack && n < 8);
        check({cur_name, " ack latency"}, 1, n);
        rd = wb_dat_o;
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [15:0] dat);
        logic [15:0] unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic wait_idle(output logic [15:0] st);
        repeat (2) @(posedge CLK);   // let busy rise first
        do
            wb_access(1'b0, `EE_REG_CMD, 16'd0, st);
        while (st[0]);
    endtask

    initial
    begin : main
        logic [15:0] st;
        logic [7:0]  d1;
        logic [7:0]  d2;
        int          errs_before;
        int          stops_before;

        for (int a = 0; a < 2048; a++)
            ref_mem[a] = 8'(a) ^ {3'(a >> 8), 2'b00, 3'(a >> 8)};
        set_test(0,  "wr_rand",    OP_WR,      11'h123, 1'b0, 1'b0);
        set_test(1,  "rd_rand",    OP_RD,      11'h123, 1'b0, 1'b0);
        set_test(2,  "wr_page0",   OP_WR,      11'h0A5, 1'b0, 1'b0);
        set_test(3,  "wr_page3",   OP_WR,      11'h3A5, 1'b0, 1'b0);
        set_test(4,  "wr_page7",   OP_WR,      11'h7A5, 1'b0, 1'b0);
        set_test(5,  "rd_page0",   OP_RD,      11'h0A5, 1'b0, 1'b0);
        set_test(6,  "rd_page3",   OP_RD,      11'h3A5, 1'b0, 1'b0);
        set_test(7,  "rd_page7",   OP_RD,      11'h7A5, 1'b0, 1'b0);
        set_test(8,  "wr_absent",  OP_WR,      11'h200, 1'b1, 1'b1);
        set_test(9,  "rd_present", OP_RD,      11'h3A5, 1'b0, 1'b0);
        set_test(10, "wr_busy",    OP_WR_BUSY, 11'h456, 1'b0, 1'b0);
        set_test(11, "rd_busy",    OP_RD,      11'h456, 1'b0, 1'b0);

        repeat (3) @(posedge CLK);
        #2;
        RESET = 1'b0;

        errs_before = errors;
        wb_access(1'b0, `EE_REG_CMD, 16'd0, st);
        check("reset busy", 0, int'(st[0]));
        check("reset nack", 0, int'(st[1]));
        $display("%-12s %s", cur_name, (errors == errs_before) ? "ok" : "mismatch");

        for (int i = 0; i < NUM_TESTS; i++)
        begin
            cur_name     = t_name[i];
            errs_before  = errors;
            stops_before = stops;
            model_absent = t_absent[i];
            rand_byte(d1);
            rand_byte(d2);
            if (d2 == d1)
                d2 = ~d1;
            wb_write(`EE_REG_ADDR, {5'd0, t_addr[i]});
            wb_write(`EE_REG_WDATA, {8'd0, d1});
            wb_write(`EE_REG_CMD, (t_op[i] == OP_RD) ? {14'd0, `EE_CMD_READ}
                                                     : {14'd0, `EE_CMD_WRITE});
            if (t_op[i] == OP_WR_BUSY)
            begin
                repeat (2) @(posedge CLK);
                wb_access(1'b0, `EE_REG_CMD, 16'd0, st);
                check({cur_name, " busy set"}, 1, int'(st[0]));
                wb_write(`EE_REG_WDATA, {8'd0, d2});
                wb_write(`EE_REG_CMD, {14'd0, `EE_CMD_WRITE});
            end
            wait_idle(st);
            check({cur_name, " nack"}, int'(t_nack[i]), int'(st[1]));
            check({cur_name, " stops"}, 1, stops - stops_before);
            if (t_op[i] != OP_RD && !t_nack[i])
                ref_mem[t_addr[i]] = d1;
            if (t_op[i] == OP_RD && !t_nack[i])
                check({cur_name, " rdata"}, int'(ref_mem[t_addr[i]]), int'(st[15:8]));
            $display("%-12s %s", cur_name, (errors == errs_before) ? "ok" : "mismatch");
        end

        if (proto_errs != 0)
        begin
            $display("bus model saw %0d protocol errors", proto_errs);
            errors++;
        end
        $display("tests %0d, failed checks %0d", NUM_TESTS + 1, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+design
design/eeprom_pkg.sv
design/eeprom_wb_regs.sv
design/eeprom_byte_fsm.sv
design/i2c_bit_ctrl.sv
design/eeprom_ctrl_top.sv
verification/i2c_eeprom_model.sv
verification/tb_eeprom_ctrl.sv

// File: Makefile
# Verilator simulation of the EEPROM controller

VERILATOR ?= verilator
TOP       ?= tb_eeprom_ctrl
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
